// File: Bender.yml
package:
  name: scan_doubler

sources:
  - scan_pkg.sv
  - line_buffer.sv
  - line_writer.sv
  - line_sync.sv
  - scan_timer.sv
  - scan_fsm.sv
  - scan_doubler.sv
  - target: test
    files:
      - tb_scan_doubler.sv

// File: line_buffer.sv
module line_buffer (
	input  logic                 clk_pix,
	input  logic                 clk_vga,
	input  logic                 wr_en,
	input  logic                 wr_bank,
	input  scan_pkg::line_addr_t wr_addr,
	input  scan_pkg::pixel_t     wr_data,
	input  logic                 rd_bank,
	input  scan_pkg::line_addr_t rd_addr,
	output scan_pkg::pixel_t     rd_data
);
	import scan_pkg::*;

	// two game lines, bank in the top address bit
	pixel_t mem [0:511];

	always_ff @(posedge clk_pix) begin
		if (wr_en) begin
			mem[{wr_bank, wr_addr}] <= wr_data;
		end
	end

	always_ff @(posedge clk_vga) begin
		rd_data <= mem[{rd_bank, rd_addr}]; // valid one cycle after rd_addr
	end

endmodule

// File: line_sync.sv
module line_sync (
	input  logic clk_vga,
	input  logic rst,
	input  logic line_req,
	input  logic wr_bank,
	input  logic vblank_n,
	output logic line_ack,
	output logic line_start,
	output logic vblank_start,
	output logic rd_bank
);

	logic req_meta;
	logic req_sync;
	logic bank_meta;
	logic bank_sync;
	logic vbl_meta;
	logic vbl_sync;
	logic vbl_last;
	logic req_rise;

	// line_ack holds last cycle's req_sync
	assign req_rise = req_sync && !line_ack;

	always_ff @(posedge clk_vga) begin
		if (rst) begin
			req_meta  <= 1'b0;
			req_sync  <= 1'b0;
			bank_meta <= 1'b0;
			bank_sync <= 1'b0;
			vbl_meta  <= 1'b1;
			vbl_sync  <= 1'b1;
			vbl_last  <= 1'b1;
		end else begin
			req_meta  <= line_req;
			req_sync  <= req_meta;
			bank_meta <= wr_bank;
			bank_sync <= bank_meta;
			vbl_meta  <= vblank_n;
			vbl_sync  <= vbl_meta;
			vbl_last  <= vbl_sync;
		end
	end

	always_ff @(posedge clk_vga) begin
		if (rst) begin
			line_ack     <= 1'b0;
			line_start   <= 1'b0;
			vblank_start <= 1'b0;
			rd_bank      <= 1'b1; // writer starts on bank 0
		end else begin
			line_ack     <= req_sync; // ack follows req both ways
			line_start   <= req_rise;
			vblank_start <= vbl_last && !vbl_sync;
			if (req_rise) rd_bank <= ~bank_sync; // held for the line pair
		end
	end

endmodule

// File: line_writer.sv
module line_writer #(
	parameter int LINE_PIXELS = scan_pkg::DEF_LINE_PIXELS
) (
	input  logic                 clk_pix,
	input  logic                 rst,
	input  scan_pkg::color_t     red,
	input  scan_pkg::color_t     green,
	input  scan_pkg::color_t     blue,
	input  logic                 hblank_n,
	input  logic                 line_ack,
	output logic                 wr_en,
	output logic                 wr_bank,
	output scan_pkg::line_addr_t wr_addr,
	output scan_pkg::pixel_t     wr_data,
	output logic                 line_req
);
	import scan_pkg::*;

	localparam line_addr_t LAST_ADDR = line_addr_t'(LINE_PIXELS - 1);

	logic ack_meta;
	logic ack_sync;
	logic req_pend;
	logic hblank_fall;

	// wr_en is hblank_n one clock late
	assign hblank_fall = wr_en && !hblank_n;

	always_ff @(posedge clk_pix) begin
		wr_data <= {red, green, blue};
	end

	always_ff @(posedge clk_pix) begin
		if (rst) begin
			wr_en   <= 1'b0;
			wr_bank <= 1'b0;
			wr_addr <= '0;
		end else begin
			wr_en <= hblank_n;
			if (hblank_fall) begin
				wr_addr <= '0;
				wr_bank <= ~wr_bank; // last pixel still lands in the old bank
			end else if (wr_en) begin
				wr_addr <= (wr_addr == LAST_ADDR) ? '0 : wr_addr + 1'b1;
			end
		end
	end

	// four-phase request towards clk_vga
	always_ff @(posedge clk_pix) begin
		if (rst) begin
			ack_meta <= 1'b0;
			ack_sync <= 1'b0;
			line_req <= 1'b0;
			req_pend <= 1'b0;
		end else begin
			ack_meta <= line_ack;
			ack_sync <= ack_meta;
			if (line_req) begin
				if (ack_sync) line_req <= 1'b0;
			end else if (req_pend && !ack_sync) begin
				line_req <= 1'b1; // previous ack gone
				req_pend <= 1'b0;
			end
			if (hblank_fall) req_pend <= 1'b1;
		end
	end

endmodule

// File: scan_doubler.sv
module scan_doubler #(
	parameter int H_SYNC      = scan_pkg::DEF_H_SYNC,
	parameter int H_FRONT     = scan_pkg::DEF_H_FRONT,
	parameter int H_BORDER    = scan_pkg::DEF_H_BORDER,
	parameter int H_BACK      = scan_pkg::DEF_H_BACK,
	parameter int LINE_PIXELS = scan_pkg::DEF_LINE_PIXELS
) (
	input  logic             clk_vga,
	input  logic             clk_pix,
	input  logic             rst,
	input  scan_pkg::color_t red,
	input  scan_pkg::color_t green,
	input  scan_pkg::color_t blue,
	input  logic             hblank_n,
	input  logic             vblank_n,
	output scan_pkg::color_t vga_red,
	output scan_pkg::color_t vga_green,
	output scan_pkg::color_t vga_blue,
	output logic             vga_hsync,
	output logic             vga_vsync
);
	import scan_pkg::*;

	logic       wr_en;
	logic       wr_bank;
	line_addr_t wr_addr;
	pixel_t     wr_data;
	logic       line_req;
	logic       line_ack;
	logic       line_start;
	logic       vblank_start;
	logic       rd_bank;
	logic       rd_bank_q;
	line_addr_t rd_addr;
	pixel_t     rd_data;
	logic       timer_load;
	scan_cnt_t  timer_val;
	logic       timer_done;

	line_writer #(
		.LINE_PIXELS (LINE_PIXELS)
	) u_writer (
		.clk_pix  (clk_pix),
		.rst      (rst),
		.red      (red),
		.green    (green),
		.blue     (blue),
		.hblank_n (hblank_n),
		.line_ack (line_ack),
		.wr_en    (wr_en),
		.wr_bank  (wr_bank),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.line_req (line_req)
	);

	line_buffer u_buffer (
		.clk_pix (clk_pix),
		.clk_vga (clk_vga),
		.wr_en   (wr_en),
		.wr_bank (wr_bank),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_bank (rd_bank_q),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	line_sync u_sync (
		.clk_vga      (clk_vga),
		.rst          (rst),
		.line_req     (line_req),
		.wr_bank      (wr_bank),
		.vblank_n     (vblank_n),
		.line_ack     (line_ack),
		.line_start   (line_start),
		.vblank_start (vblank_start),
		.rd_bank      (rd_bank)
	);

	scan_timer u_timer (
		.clk_vga  (clk_vga),
		.rst      (rst),
		.load     (timer_load),
		.load_val (timer_val),
		.done     (timer_done)
	);

	scan_fsm #(
		.H_SYNC      (H_SYNC),
		.H_FRONT     (H_FRONT),
		.H_BORDER    (H_BORDER),
		.H_BACK      (H_BACK),
		.LINE_PIXELS (LINE_PIXELS)
	) u_fsm (
		.clk_vga      (clk_vga),
		.rst          (rst),
		.line_start   (line_start),
		.vblank_start (vblank_start),
		.rd_bank      (rd_bank),
		.rd_data      (rd_data),
		.timer_done   (timer_done),
		.timer_load   (timer_load),
		.timer_val    (timer_val),
		.rd_bank_q    (rd_bank_q),
		.rd_addr      (rd_addr),
		.vga_red      (vga_red),
		.vga_green    (vga_green),
		.vga_blue     (vga_blue),
		.vga_hsync    (vga_hsync),
		.vga_vsync    (vga_vsync)
	);

endmodule

// File: scan_fsm.sv
module scan_fsm #(
	parameter int H_SYNC      = scan_pkg::DEF_H_SYNC,
	parameter int H_FRONT     = scan_pkg::DEF_H_FRONT,
	parameter int H_BORDER    = scan_pkg::DEF_H_BORDER,
	parameter int H_BACK      = scan_pkg::DEF_H_BACK,
	parameter int LINE_PIXELS = scan_pkg::DEF_LINE_PIXELS
) (
	input  logic                 clk_vga,
	input  logic                 rst,
	input  logic                 line_start,
	input  logic                 vblank_start,
	input  logic                 rd_bank,
	input  scan_pkg::pixel_t     rd_data,
	input  logic                 timer_done,
	output logic                 timer_load,
	output scan_pkg::scan_cnt_t  timer_val,
	output logic                 rd_bank_q,
	output scan_pkg::line_addr_t rd_addr,
	output scan_pkg::color_t     vga_red,
	output scan_pkg::color_t     vga_green,
	output scan_pkg::color_t     vga_blue,
	output logic                 vga_hsync,
	output logic                 vga_vsync
);
	import scan_pkg::*;

	scan_state_t state;
	scan_state_t state_nxt;
	logic        wait_line; // this SYNC ends on line_start
	logic        half;
	logic        vs_req;
	logic        vs_cnt;
	logic        line_end;
	pixel_t      pix_q;

	function automatic scan_cnt_t seg_len(input scan_state_t s);
		case (s)
			SYNC:     seg_len = scan_cnt_t'(H_SYNC - 1);
			FRONT:    seg_len = scan_cnt_t'(H_FRONT - 1);
			BORDER_L: seg_len = scan_cnt_t'(H_BORDER - 1);
			ACTIVE:   seg_len = scan_cnt_t'(2 * LINE_PIXELS - 1);
			BORDER_R: seg_len = scan_cnt_t'(H_BORDER - 1);
			default:  seg_len = scan_cnt_t'(H_BACK - 1);
		endcase
	endfunction

	always_comb begin
		state_nxt = state;
		case (state)
			SYNC:     if (wait_line ? line_start : timer_done) state_nxt = FRONT;
			FRONT:    if (timer_done) state_nxt = BORDER_L;
			BORDER_L: if (timer_done) state_nxt = ACTIVE;
			ACTIVE:   if (timer_done) state_nxt = BORDER_R;
			BORDER_R: if (timer_done) state_nxt = BACK;
			BACK:     if (timer_done) state_nxt = SYNC;
			default:  state_nxt = SYNC;
		endcase
	end

	assign timer_load = (state_nxt != state);
	assign timer_val  = seg_len(state_nxt);
	assign line_end   = (state == BACK) && timer_done;

	assign vga_red   = pix_q[11:8];
	assign vga_green = pix_q[7:4];
	assign vga_blue  = pix_q[3:0];

	always_ff @(posedge clk_vga) begin
		if (rst) begin
			state     <= SYNC;
			wait_line <= 1'b0;
			half      <= 1'b0;
			rd_addr   <= '0;
			rd_bank_q <= 1'b0;
			pix_q     <= '0;
			vga_hsync <= 1'b1;
			vga_vsync <= 1'b1;
			vs_req    <= 1'b0;
			vs_cnt    <= 1'b0;
		end else begin
			state     <= state_nxt;
			vga_hsync <= (state_nxt != SYNC);
			if (state == SYNC && state_nxt == FRONT) begin
				wait_line <= ~wait_line; // timed and locked lines alternate
				rd_bank_q <= rd_bank;
			end
			// rd_addr runs one cycle ahead of the buffer output
			if (state == ACTIVE) begin
				half  <= ~half;
				pix_q <= rd_data;
				if (!half) rd_addr <= rd_addr + 1'b1;
			end else begin
				half    <= 1'b0;
				rd_addr <= '0;
				pix_q   <= '0;
			end
			if (vblank_start) vs_req <= 1'b1;
			if (line_end) begin
				if (!vga_vsync) begin
					vs_cnt <= ~vs_cnt;
					if (vs_cnt) vga_vsync <= 1'b1; // two lines done
				end else if (vs_req) begin
					vga_vsync <= 1'b0;
					vs_req    <= 1'b0;
				end
			end
		end
	end

endmodule

// File: scan_pkg.sv
package scan_pkg;

	typedef logic [3:0]  color_t;     // one colour component
	typedef logic [11:0] pixel_t;     // {red, green, blue}
	typedef logic [7:0]  line_addr_t; // pixel index in a game line
	typedef logic [9:0]  scan_cnt_t;  // segment timer

	typedef enum logic [2:0] {
		SYNC,
		FRONT,
		BORDER_L,
		ACTIVE,
		BORDER_R,
		BACK
	} scan_state_t;

	// default horizontal timing in clk_vga cycles
	localparam int DEF_H_SYNC      = 96;
	localparam int DEF_H_FRONT     = 16;
	localparam int DEF_H_BORDER    = 64;
	localparam int DEF_H_BACK      = 48;
	localparam int DEF_LINE_PIXELS = 256; // game pixels per line, max 256

endpackage

// File: scan_timer.sv
module scan_timer (
	input  logic                clk_vga,
	input  logic                rst,
	input  logic                load,
	input  scan_pkg::scan_cnt_t load_val,
	output logic                done
);
	import scan_pkg::*;

	scan_cnt_t cnt;

	// a load of N gives N+1 cycles including the done cycle
	always_ff @(posedge clk_vga) begin
		if (rst) begin
			cnt <= load_val; // fsm offers the SYNC length while in reset
		end else if (load) begin
			cnt <= load_val;
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1; // parks at zero
		end
	end

	assign done = (cnt == '0);

endmodule

// File: tb_scan_doubler.sv
module tb_scan_doubler;

	localparam int CLK_VGA_HALF = 50;
	localparam int CLK_PIX_HALF = 250;
	localparam int DRIVE_DLY    = 10;
	localparam int RESET_CYCLES = 16;

	// game video format
	localparam int GAME_PIXELS = 256;
	localparam int GAME_LINE   = 320;
	localparam int FRAME_LINES = 40;
	localparam int VBL_FIRST   = 32;
	localparam int NUM_FRAMES  = 4;
	localparam int TOTAL_LINES = NUM_FRAMES * FRAME_LINES;

	// vga line layout
	localparam int VGA_LINE  = 800;
	localparam int SYNC_LEN  = 96;
	localparam int HIGH_LEN  = VGA_LINE - SYNC_LEN;
	localparam int WIN_START = 16 + 64 + 1; // front, left border, output register
	localparam int WIN_LEN   = 2 * GAME_PIXELS;

	localparam int TIMEOUT_CYCLES = 6 * FRAME_LINES * 2 * VGA_LINE + 4 * VGA_LINE;

	localparam int T_RESET   = 0;
	localparam int T_HTIME   = 1;
	localparam int T_PIXEL   = 2;
	localparam int T_DOUBLE  = 3;
	localparam int T_BLANK   = 4;
	localparam int T_VSYNC   = 5;
	localparam int NUM_TESTS = 6;

	logic       clk_vga;
	logic       clk_pix;
	logic       rst;
	logic [3:0] red;
	logic [3:0] green;
	logic [3:0] blue;
	logic       hblank_n;
	logic       vblank_n;
	logic [3:0] vga_red;
	logic [3:0] vga_green;
	logic [3:0] vga_blue;
	logic       vga_hsync;
	logic       vga_vsync;

	int          seed = 24;
	logic [11:0] offset;
	int          errors [NUM_TESTS];
	string       test_name [NUM_TESTS] = '{"reset", "horizontal timing", "pixel doubling",
		"line doubling", "blanking", "vsync"};
	int          cycle_cnt = 0;
	int          last_done_line = -1; // most recent game line with hblank reached
	bit          reset_done = 1'b0;
	bit          game_done = 1'b0;

	logic        hs;
	logic        vs;
	logic        hs_fall;
	logic        hs_rise;
	logic        prev_hs = 1'b1;
	logic        prev_vs = 1'b1;
	logic [11:0] colour;
	logic [11:0] cap [WIN_LEN];
	logic [11:0] prev_cap [WIN_LEN];
	bit          reset_reported = 1'b0;
	bit          seen_rise = 1'b0;
	bit          in_line = 1'b0;
	bit          in_vs = 1'b0;
	int          high_len = 0;
	int          low_len = 0;
	int          low_count = 0;
	int          n_timed = 0;
	int          vga_line = -1;
	int          pos = 0;
	int          exp_line = -1;
	int          prev_exp = -1;
	int          n_shown = 0;
	int          n_doubled = 0;
	int          diffs;
	int          vs_lines = 0;
	int          vs_pulses = 0;

	scan_doubler i_dut (
		.clk_vga   (clk_vga),
		.clk_pix   (clk_pix),
		.rst       (rst),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.hblank_n  (hblank_n),
		.vblank_n  (vblank_n),
		.vga_red   (vga_red),
		.vga_green (vga_green),
		.vga_blue  (vga_blue),
		.vga_hsync (vga_hsync),
		.vga_vsync (vga_vsync)
	);

	// game pixel for a line, pixel index and run offset
	function automatic logic [11:0] pix_ref(input int line, input int px, input logic [11:0] ofs);
		logic [31:0] mix;
		mix = line * 179 + px * 21 + ofs;
		pix_ref = mix[11:0] ^ {px[7:0], 4'h0};
	endfunction

	task automatic check(input int test, input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
			errors[test]++;
		end
	endtask

	task automatic report_test(input int test);
		if (errors[test] == 0) begin
			$display("%s: passed", test_name[test]);
		end else begin
			$display("%s: failed with %0d errors", test_name[test], errors[test]);
		end
	endtask

	initial begin
		clk_vga = 1'b0;
		forever #CLK_VGA_HALF clk_vga = ~clk_vga;
	end

	initial begin
		clk_pix = 1'b0;
		forever #CLK_PIX_HALF clk_pix = ~clk_pix;
	end

	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk_vga);
			cycle_cnt++;
		end
		$display("timeout: the run did not finish within %0d clk_vga cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	// game video source driving one pixel per clk_pix
	initial begin
		wait (reset_done);
		for (int g = 0; g < TOTAL_LINES; g++) begin
			for (int c = 0; c < GAME_LINE; c++) begin
				@(posedge clk_pix);
				#DRIVE_DLY;
				if (c == 0) begin
					vblank_n = ((g % FRAME_LINES) < VBL_FIRST);
				end
				if (c < GAME_PIXELS) begin
					hblank_n = 1'b1;
					{red, green, blue} = pix_ref(g, c, offset);
				end else begin
					hblank_n = 1'b0;
					{red, green, blue} = '0;
					if (c == GAME_PIXELS) begin
						last_done_line = g;
					end
				end
			end
		end
		game_done = 1'b1;
	end

	initial begin
		int pass_cnt;
		int fail_cnt;
		rst      = 1'b1;
		red      = '0;
		green    = '0;
		blue     = '0;
		hblank_n = 1'b0;
		vblank_n = 1'b1;
		offset   = 12'($random(seed));
		repeat (RESET_CYCLES) @(posedge clk_vga);
		#DRIVE_DLY;
		rst        = 1'b0;
		reset_done = 1'b1;
		wait (game_done);
		repeat (2 * VGA_LINE) @(posedge clk_vga); // last line pair still on screen
		if (n_timed == 0) begin
			$display("horizontal timing: no timed hsync pulse was measured");
			errors[T_HTIME]++;
		end
		check(T_PIXEL, "lines with checked pixels", n_shown, 2 * TOTAL_LINES);
		check(T_DOUBLE, "doubled line pairs", n_doubled, TOTAL_LINES);
		check(T_VSYNC, "vsync pulses", vs_pulses, NUM_FRAMES);
		pass_cnt = 0;
		fail_cnt = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			if (t != T_RESET) begin
				report_test(t);
			end
			if (errors[t] == 0) begin
				pass_cnt++;
			end else begin
				fail_cnt++;
			end
		end
		$display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// sampled on the falling clk_vga edge
	always @(negedge clk_vga) begin
		hs     = vga_hsync;
		vs     = vga_vsync;
		colour = {vga_red, vga_green, vga_blue};
		if (cycle_cnt > 0 && (rst || !reset_reported)) begin
			check(T_RESET, "vga_hsync", hs, 1'b1);
			check(T_RESET, "vga_vsync", vs, 1'b1);
			check(T_RESET, "{vga_red,vga_green,vga_blue}", colour, 12'h000);
			if (!rst) begin
				reset_reported = 1'b1;
				report_test(T_RESET);
			end
		end
		if (cycle_cnt > 0 && !rst) begin
			hs_fall = prev_hs && !hs;
			hs_rise = !prev_hs && hs;
			if (hs_fall) begin
				if (seen_rise) begin
					check(T_HTIME, "vga_hsync high cycles", high_len, HIGH_LEN);
				end
				low_len = 1;
			end else if (!hs) begin
				low_len++;
			end
			if (hs_rise) begin
				// pulse 0 is cut short by reset and the even pulses after it are timed
				if (low_count >= 2 && low_count % 2 == 0) begin
					check(T_HTIME, "vga_hsync low cycles", low_len, SYNC_LEN);
					n_timed++;
				end
				low_count++;
				high_len  = 1;
				seen_rise = 1'b1;
				vga_line++;
				pos      = 0;
				in_line  = 1'b1;
				exp_line = last_done_line;
			end else begin
				if (hs) begin
					high_len++;
				end
				pos++;
			end

			if (in_line && pos >= WIN_START && pos < WIN_START + WIN_LEN) begin
				cap[pos - WIN_START] = colour;
				if (exp_line >= 0) begin
					check(T_PIXEL, "{vga_red,vga_green,vga_blue}", colour,
						pix_ref(exp_line, (pos - WIN_START) / 2, offset));
				end
			end else begin
				check(T_BLANK, "{vga_red,vga_green,vga_blue}", colour, 12'h000);
			end

			if (in_line && pos == WIN_START + WIN_LEN && exp_line >= 0) begin
				n_shown++;
				if (vga_line % 2 == 0 && prev_exp >= 0) begin // second line of a pair
					diffs = 0;
					for (int k = 0; k < WIN_LEN; k++) begin
						if (cap[k] !== prev_cap[k]) begin
							diffs++;
						end
					end
					check(T_DOUBLE, "pixels differing from first line of pair", diffs, 0);
					n_doubled++;
				end else if (vga_line % 2 == 1 && prev_exp >= 0) begin
					check(T_DOUBLE, "game line of new pair", exp_line, prev_exp + 1);
				end
				prev_cap = cap;
				prev_exp = exp_line;
			end

			if (in_vs && hs_fall) begin
				vs_lines++;
			end
			if (!prev_vs && vs) begin
				check(T_VSYNC, "vga_hsync fall at vsync rise", hs_fall, 1'b1);
				check(T_VSYNC, "vga_vsync low lines", vs_lines, 2);
				in_vs = 1'b0;
			end
			if (prev_vs && !vs) begin
				check(T_VSYNC, "vga_hsync fall at vsync fall", hs_fall, 1'b1);
				in_vs    = 1'b1;
				vs_lines = 0;
				vs_pulses++;
			end
			prev_hs = hs;
			prev_vs = vs;
		end
	end

endmodule

// File: vlog.f
scan_pkg.sv
line_buffer.sv
line_writer.sv
line_sync.sv
scan_timer.sv
scan_fsm.sv
scan_doubler.sv
tb_scan_doubler.sv
